/* include/acq_defs.svh */
// acq block macros: channel count, sample/sum/fill/count widths, fifo depth, apb widths
`ifndef ACQ_DEFS_SVH
`define ACQ_DEFS_SVH

// channels in the block
`define ACQ_NUM_CHAN 5

// fill number carried in each record
`define ACQ_FILL_W 24

`define ACQ_SAMPLE_W 12   // one adc sample
`define ACQ_SUM_W 20      // 255 samples of 12 bits
`define ACQ_CNT_W 8       // samples per fill

// samples per fill out of reset
`define ACQ_SAMPLES_RST 16

`define ACQ_FIFO_DEPTH 4  // fill records held

// apb bus widths
`define APB_ADDR_W 8
`define APB_DATA_W 32

`endif

/* src/acq_pkg.sv */
// acquisition types: trigger manager state enum and fill record struct
`include "acq_defs.svh"

package acq_pkg;

  // codes are also the bit positions of the one-hot state vector
  typedef enum logic [1:0] {
    IDLE          = 2'd0,
    FILL          = 2'd1,
    SET_TRIG_ARM  = 2'd2,
    STORE_FILLNUM = 2'd3
  } tm_state_e;

  // one entry of the record fifo, 32 bits
  typedef struct packed {
    logic [`ACQ_FILL_W-1:0] fill_num;  // fill this record belongs to
    logic [`ACQ_CNT_W-1:0]  samples;   // samples per fill in force for it
  } fill_rec_t;

endpackage

/* src/apb_pkg.sv */
// apb types: request and response structs, register offset enum
`include "acq_defs.svh"

package apb_pkg;

  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [`APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apb_rsp_t;

  // byte offsets of the acquisition registers
  typedef enum logic [`APB_ADDR_W-1:0] {
    CTRL         = 8'h00,  // bit 0 hold
    SAMPLES      = 8'h04,
    STATUS       = 8'h08,  // state, fifo count, fill number
    FIFO_POP     = 8'h0C,  // read pops a record
    READOUT_DONE = 8'h10,  // write strobe
    CHAN_SUM0    = 8'h20,
    CHAN_SUM1    = 8'h24,
    CHAN_SUM2    = 8'h28,
    CHAN_SUM3    = 8'h2C,
    CHAN_SUM4    = 8'h30
  } acq_reg_e;

endpackage

/* src/trigger_manager.sv */
// trigger_manager: one-hot fill control fsm with fill counter, go, arm and record push
`include "acq_defs.svh"

module trigger_manager (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     trigger,
  input  logic                     hold,
  input  logic [`ACQ_NUM_CHAN-1:0] done,
  input  logic                     readout_done,
  input  logic                     push_ready,
  output logic                     go,
  output logic [`ACQ_NUM_CHAN-1:0] arm,
  output logic                     push_valid,
  output acq_pkg::fill_rec_t       push_rec,
  input  logic [`ACQ_CNT_W-1:0]    samples,
  output acq_pkg::tm_state_e       state,
  output logic [`ACQ_FILL_W-1:0]   fill_num
);

  logic [3:0]             cur_oh;         // one-hot, indexed by tm_state_e
  logic [3:0]             next_oh;
  logic [`ACQ_FILL_W-1:0] next_fill_num;
  logic [`ACQ_CNT_W-1:0]  fill_samples;   // samples value taken at fill start

  always_comb begin
    next_oh       = '0;
    next_fill_num = fill_num;
    case (1'b1)
      cur_oh[acq_pkg::IDLE]: begin
        if (trigger && !hold) begin
          next_oh[acq_pkg::FILL] = 1'b1;
          next_fill_num          = fill_num + 1'b1;
        end else begin
          next_oh[acq_pkg::IDLE] = 1'b1;
        end
      end
      cur_oh[acq_pkg::FILL]: begin
        if (&done) next_oh[acq_pkg::STORE_FILLNUM] = 1'b1;  // every channel finished
        else next_oh[acq_pkg::FILL] = 1'b1;
      end
      cur_oh[acq_pkg::STORE_FILLNUM]: begin
        if (push_ready) next_oh[acq_pkg::SET_TRIG_ARM] = 1'b1;  // record taken this cycle
        else next_oh[acq_pkg::STORE_FILLNUM] = 1'b1;
      end
      cur_oh[acq_pkg::SET_TRIG_ARM]: begin
        if (readout_done) next_oh[acq_pkg::IDLE] = 1'b1;
        else next_oh[acq_pkg::SET_TRIG_ARM] = 1'b1;
      end
      default: next_oh[acq_pkg::IDLE] = 1'b1;  // lost one-hot code
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cur_oh   <= 4'b0001 << acq_pkg::IDLE;
      fill_num <= '0;
    end else begin
      cur_oh   <= next_oh;
      fill_num <= next_fill_num;
    end
  end

  always_ff @(posedge clk) begin
    if (cur_oh[acq_pkg::IDLE] && next_oh[acq_pkg::FILL]) fill_samples <= samples;
  end

  // outputs registered from the next state, so they line up with the state
  always_ff @(posedge clk) begin
    if (reset) begin
      go         <= 1'b0;
      push_valid <= 1'b0;
      arm        <= '1;
    end else begin
      go         <= 1'b0;
      push_valid <= 1'b0;
      arm        <= '1;
      case (1'b1)
        next_oh[acq_pkg::FILL]: go <= 1'b1;
        next_oh[acq_pkg::STORE_FILLNUM]: begin
          push_valid <= 1'b1;
          arm        <= '0;
        end
        next_oh[acq_pkg::SET_TRIG_ARM]: arm <= '0;  // front ends stay off until readout
        default: ;
      endcase
    end
  end

  always_comb begin
    case (1'b1)
      cur_oh[acq_pkg::FILL]:          state = acq_pkg::FILL;
      cur_oh[acq_pkg::STORE_FILLNUM]: state = acq_pkg::STORE_FILLNUM;
      cur_oh[acq_pkg::SET_TRIG_ARM]:  state = acq_pkg::SET_TRIG_ARM;
      default:                        state = acq_pkg::IDLE;
    endcase
  end

  assign push_rec.fill_num = fill_num;
  assign push_rec.samples  = fill_samples;

endmodule

/* src/channel_accumulator.sv */
// channel_accumulator: sums a programmable number of samples per fill, flags done
`include "acq_defs.svh"

module channel_accumulator (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     go,
  input  logic [`ACQ_CNT_W-1:0]    samples,
  input  logic [`ACQ_SAMPLE_W-1:0] sample,
  output logic [`ACQ_SUM_W-1:0]    sum,
  output logic                     done
);

  logic                  go_d;
  logic                  start;
  logic [`ACQ_CNT_W-1:0] remain;  // samples still to add this fill

  // start cycle on the first cycle of go
  assign start = go && !go_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      go_d   <= 1'b0;
      remain <= '0;
      sum    <= '0;
    end else begin
      go_d <= go;
      if (start) begin
        sum <= '0;
        // a zero count still takes one sample
        remain <= (samples == '0) ? `ACQ_CNT_W'(1) : samples;
      end else if (remain != '0) begin
        sum    <= sum + `ACQ_SUM_W'(sample);
        remain <= remain - 1'b1;
      end
    end
  end

  // Raised in the cycle of the last sample, so the manager leaves FILL on the
  // same edge that completes the sum. The start cycle masks the done left
  // over from the previous fill.
  assign done = !start && (remain <= `ACQ_CNT_W'(1));

endmodule

/* src/fill_fifo.sv */
// fill_fifo: circular record buffer, valid/ready write side, pop read side
`include "acq_defs.svh"

module fill_fifo (
  input  logic               clk,
  input  logic               reset,
  input  logic               push_valid,
  input  acq_pkg::fill_rec_t push_rec,
  output logic               push_ready,
  input  logic               pop,
  output acq_pkg::fill_rec_t pop_rec,
  output logic [2:0]         count,
  output logic               empty
);

  localparam int DEPTH = `ACQ_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  acq_pkg::fill_rec_t mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic               do_push;
  logic               do_pop;

  assign push_ready = (count != 3'(DEPTH));  // room for one more
  assign empty      = (count == '0);
  assign do_push    = push_valid && push_ready;
  assign do_pop     = pop && !empty;  // pop on empty is dropped
  assign pop_rec    = mem[rd_ptr];    // head of queue

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_rec;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

endmodule

/* src/acq_regs.sv */
// acq_regs: apb slave with control, samples, status, fifo pop, readout done, channel sums
`include "acq_defs.svh"

module acq_regs (
  input  logic                                      clk,
  input  logic                                      reset,
  input  apb_pkg::apb_req_t                         apb_in,
  output apb_pkg::apb_rsp_t                         apb_out,
  output logic                                      hold,
  output logic [`ACQ_CNT_W-1:0]                     samples,
  output logic                                      readout_done,
  input  acq_pkg::tm_state_e                        state,
  input  logic [`ACQ_FILL_W-1:0]                    fill_num,
  input  logic [2:0]                                fifo_count,
  input  logic                                      fifo_empty,
  input  acq_pkg::fill_rec_t                        pop_rec,
  output logic                                      pop,
  input  logic [`ACQ_NUM_CHAN-1:0][`ACQ_SUM_W-1:0] sums
);

  logic                   access;  // second apb cycle
  logic                   wr;
  logic                   rd;
  apb_pkg::acq_reg_e      addr;
  logic                   mapped;
  logic [`APB_DATA_W-1:0] rdata;

  assign access = apb_in.psel && apb_in.penable;
  assign wr     = access && apb_in.pwrite;
  assign rd     = access && !apb_in.pwrite;
  assign addr   = apb_pkg::acq_reg_e'(apb_in.paddr);

  // read mux and offset decode
  always_comb begin
    mapped = 1'b1;
    rdata  = '0;
    case (addr)
      apb_pkg::CTRL:         rdata = `APB_DATA_W'(hold);
      apb_pkg::SAMPLES:      rdata = `APB_DATA_W'(samples);
      apb_pkg::STATUS:       rdata = {fill_num, 1'b0, fifo_count, 2'b00, state};
      apb_pkg::FIFO_POP:     rdata = fifo_empty ? '1 : `APB_DATA_W'(pop_rec);
      apb_pkg::READOUT_DONE: rdata = '0;  // write-only strobe
      apb_pkg::CHAN_SUM0:    rdata = `APB_DATA_W'(sums[0]);
      apb_pkg::CHAN_SUM1:    rdata = `APB_DATA_W'(sums[1]);
      apb_pkg::CHAN_SUM2:    rdata = `APB_DATA_W'(sums[2]);
      apb_pkg::CHAN_SUM3:    rdata = `APB_DATA_W'(sums[3]);
      apb_pkg::CHAN_SUM4:    rdata = `APB_DATA_W'(sums[4]);
      default:               mapped = 1'b0;
    endcase
  end

  // no wait states
  assign apb_out.prdata  = rdata;
  assign apb_out.pready  = 1'b1;
  assign apb_out.pslverr = access && !mapped;

  // one-cycle strobes on the access cycle
  assign pop          = rd && (addr == apb_pkg::FIFO_POP);
  assign readout_done = wr && (addr == apb_pkg::READOUT_DONE);

  always_ff @(posedge clk) begin
    if (reset) begin
      hold    <= 1'b0;
      samples <= `ACQ_CNT_W'(`ACQ_SAMPLES_RST);
    end else if (wr) begin
      case (addr)
        apb_pkg::CTRL:    hold <= apb_in.pwdata[0];
        apb_pkg::SAMPLES: samples <= apb_in.pwdata[`ACQ_CNT_W-1:0];
        default:          ;  // read-only or strobe offsets
      endcase
    end
  end

endmodule

/* src/acq_top.sv */
// acq_top: trigger manager, channel accumulators, record fifo and apb register block
`include "acq_defs.svh"

module acq_top (
  input  logic                                        clk,
  input  logic                                        reset,
  input  apb_pkg::apb_req_t                           apb_in,
  output apb_pkg::apb_rsp_t                           apb_out,
  input  logic                                        trigger,
  input  logic [`ACQ_NUM_CHAN-1:0][`ACQ_SAMPLE_W-1:0] sample_data,
  output logic [`ACQ_NUM_CHAN-1:0]                    arm,
  output logic                                        fifo_nonempty
);

  logic                                     go;
  logic [`ACQ_NUM_CHAN-1:0]                 done;
  logic                                     hold;
  logic                                     readout_done;
  logic [`ACQ_CNT_W-1:0]                    samples;
  acq_pkg::tm_state_e                       state;
  logic [`ACQ_FILL_W-1:0]                   fill_num;
  logic                                     push_valid;
  logic                                     push_ready;
  acq_pkg::fill_rec_t                       push_rec;
  acq_pkg::fill_rec_t                       pop_rec;
  logic                                     pop;
  logic [2:0]                               fifo_count;
  logic                                     fifo_empty;
  logic [`ACQ_NUM_CHAN-1:0][`ACQ_SUM_W-1:0] sums;

  trigger_manager tm0 (
    .clk, .reset, .trigger, .hold, .done, .readout_done, .push_ready,
    .go, .arm, .push_valid, .push_rec, .samples, .state, .fill_num
  );

  // one accumulator per channel, all started by the same go
  for (genvar i = 0; i < `ACQ_NUM_CHAN; i++) begin : chan
    channel_accumulator acc0 (
      .clk, .reset, .go, .samples,
      .sample (sample_data[i]),
      .sum    (sums[i]),
      .done   (done[i])
    );
  end

  fill_fifo fifo0 (
    .clk, .reset, .push_valid, .push_rec, .push_ready, .pop, .pop_rec,
    .count (fifo_count),
    .empty (fifo_empty)
  );

  acq_regs regs0 (
    .clk, .reset, .apb_in, .apb_out, .hold, .samples, .readout_done, .state,
    .fill_num, .fifo_count, .fifo_empty, .pop_rec, .pop, .sums
  );

  assign fifo_nonempty = !fifo_empty;

endmodule

/* test/tb_acq_top.sv */
// acq_top testbench with clock, reset, apb tasks, stimulus, reference model and checks
`include "acq_defs.svh"

module tb_acq_top;

  localparam int HIST_N = 4096;  // sample history ring in cycles
  localparam int POLL_MAX = 200;
  localparam logic [31:0] ARM_ON = (1 << `ACQ_NUM_CHAN) - 1;

  logic                                        clk;
  logic                                        reset;
  apb_pkg::apb_req_t                           apb_in;
  apb_pkg::apb_rsp_t                           apb_out;
  logic                                        trigger;
  logic [`ACQ_NUM_CHAN-1:0][`ACQ_SAMPLE_W-1:0] sample_data;
  logic [`ACQ_NUM_CHAN-1:0]                    arm;
  logic                                        fifo_nonempty;

  logic [`ACQ_NUM_CHAN-1:0][`ACQ_SAMPLE_W-1:0] hist [HIST_N];
  int          cyc = 0;
  int          fill_cnt = 0;  // fills the block should have started
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          test_no = 0;
  int          failed_tests = 0;
  int          err_mark = 0;
  logic [31:0] rec_q [$];     // records owed by the fifo in order
  string       name_q [$];
  logic [31:0] exp_q [$];
  logic [31:0] act_q [$];
  time         time_q [$];
  string       cmp_name;
  logic [31:0] cmp_exp;
  logic [31:0] cmp_act;
  time         cmp_t;
  logic [31:0] rd;
  logic        rd_err;
  int          go_cyc;
  int          spare;

  acq_top dut0 (.clk, .reset, .apb_in, .apb_out, .trigger, .sample_data, .arm, .fifo_nonempty);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // fresh samples every cycle kept for the reference sums
  initial begin
    void'($urandom(7129));
    forever begin
      @(posedge clk);
      #1;
      for (int c = 0; c < `ACQ_NUM_CHAN; c++) sample_data[c] = $urandom() % 4096;
      hist[cyc % HIST_N] = sample_data;
    end
  end

  always @(negedge clk) begin
    while (name_q.size() > 0) begin
      cmp_name = name_q.pop_front();
      cmp_exp  = exp_q.pop_front();
      cmp_act  = act_q.pop_front();
      cmp_t    = time_q.pop_front();
      check_cnt++;
      if (cmp_act !== cmp_exp) begin
        $display("ERR %0t %s expected %0h actual %0h", cmp_t, cmp_name, cmp_exp, cmp_act);
        err_cnt++;
      end
    end
  end

  // samples of the n cycles after the start cycle
  function automatic logic [`ACQ_SUM_W-1:0] ref_sum(input int ch, input int start, input int n);
    logic [`ACQ_SUM_W-1:0] acc;
    int                    cnt;
    acc = '0;
    cnt = (n == 0) ? 1 : n;
    for (int i = 1; i <= cnt; i++) acc = acc + hist[(start + i) % HIST_N][ch];
    return acc;
  endfunction

  function automatic logic [31:0] expected_rec(input int fill_no, input int n);
    acq_pkg::fill_rec_t rec;
    rec.fill_num = fill_no[`ACQ_FILL_W-1:0];
    rec.samples  = n[`ACQ_CNT_W-1:0];
    return rec;
  endfunction

  task automatic timeout_error(input string why);
    $display("%s at time %0t", why, $time);
    err_cnt++;
  endtask

  task automatic expect_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
    time_q.push_back($time);
  endtask

  task automatic drive_edge();
    @(posedge clk);
    #1;
  endtask

  task automatic apb_access(input logic [7:0] addr, input logic write, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waits;
    waits = 0;
    drive_edge();
    apb_in.psel    = 1'b1;  // setup
    apb_in.penable = 1'b0;
    apb_in.pwrite  = write;
    apb_in.paddr   = addr;
    apb_in.pwdata  = wdata;
    drive_edge();
    apb_in.penable = 1'b1;  // access
    @(negedge clk);
    while (apb_out.pready !== 1'b1 && waits < 16) begin
      waits++;
      @(negedge clk);
    end
    if (apb_out.pready !== 1'b1) timeout_error("apb access never saw pready");
    rdata = apb_out.prdata;
    err   = apb_out.pslverr;
    drive_edge();
    apb_in.psel    = 1'b0;
    apb_in.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    logic        unused_err;
    apb_access(addr, 1'b1, data, unused_rd, unused_err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_access(addr, 1'b0, '0, data, err);
  endtask

  task automatic wait_state(input logic [1:0] st);
    logic [31:0] d;
    logic        e;
    int          polls;
    polls = 0;
    apb_read(apb_pkg::STATUS, d, e);
    while (d[1:0] !== st && polls < POLL_MAX) begin
      polls++;
      apb_read(apb_pkg::STATUS, d, e);
    end
    if (d[1:0] !== st) timeout_error($sformatf("status never reached state %0d", st));
  endtask

  // one-cycle pulse and go rises at the following edge
  task automatic fire_trigger(output int start);
    drive_edge();
    trigger = 1'b1;
    start   = cyc + 1;
    drive_edge();
    trigger = 1'b0;
  endtask

  task automatic run_fill(input int n, output int start);
    apb_write(apb_pkg::SAMPLES, n);
    fire_trigger(start);
    fill_cnt++;
    rec_q.push_back(expected_rec(fill_cnt, n));
  endtask

  task automatic check_sums(input int start, input int n);
    logic [31:0] d;
    logic        e;
    for (int ch = 0; ch < `ACQ_NUM_CHAN; ch++) begin
      apb_read(8'(apb_pkg::CHAN_SUM0 + 4 * ch), d, e);
      expect_val($sformatf("chan_sum%0d", ch), 32'(ref_sum(ch, start, n)), d);
    end
  endtask

  task automatic check_pop();
    logic [31:0] d;
    logic [31:0] exp;
    logic        e;
    exp = '1;  // empty fifo reads all ones
    if (rec_q.size() > 0) exp = rec_q.pop_front();
    apb_read(apb_pkg::FIFO_POP, d, e);
    expect_val("fifo_pop", exp, d);
  endtask

  task automatic readout();
    apb_write(apb_pkg::READOUT_DONE, 32'h0);
    wait_state(acq_pkg::IDLE);
  endtask

  task automatic finish_test(input string name);
    int waits;
    waits = 0;
    while (name_q.size() != 0 && waits < 4) begin
      waits++;
      @(negedge clk);
    end
    if (name_q.size() != 0) timeout_error("compare queue did not drain");
    test_no++;
    if (err_cnt != err_mark) failed_tests++;
    $display("test %0d %s: %s", test_no, name, (err_cnt == err_mark) ? "ok" : "failed");
    err_mark = err_cnt;
  endtask

  initial begin
    reset       = 1'b1;
    trigger     = 1'b0;
    apb_in      = '0;
    sample_data = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    expect_val("arm", ARM_ON, arm);
    expect_val("fifo_nonempty", 0, fifo_nonempty);
    apb_read(apb_pkg::STATUS, rd, rd_err);
    expect_val("status.state", acq_pkg::IDLE, rd[1:0]);
    expect_val("status.count", 0, rd[6:4]);
    apb_read(apb_pkg::SAMPLES, rd, rd_err);
    expect_val("samples", 16, rd);
    finish_test("reset values");

    run_fill(10, go_cyc);
    wait_state(acq_pkg::SET_TRIG_ARM);
    expect_val("arm", 0, arm);  // front ends off during readout
    expect_val("fifo_nonempty", 1, fifo_nonempty);
    check_sums(go_cyc, 10);
    check_pop();
    finish_test("single fill");

    fire_trigger(spare);  // lands while waiting for readout
    apb_read(apb_pkg::STATUS, rd, rd_err);
    expect_val("status.state", acq_pkg::SET_TRIG_ARM, rd[1:0]);
    expect_val("status.fill_num", fill_cnt, rd[31:8]);
    readout();
    expect_val("arm", ARM_ON, arm);
    run_fill(10, go_cyc);
    wait_state(acq_pkg::SET_TRIG_ARM);
    apb_read(apb_pkg::STATUS, rd, rd_err);
    expect_val("status.fill_num", 2, rd[31:8]);
    check_sums(go_cyc, 10);
    check_pop();
    readout();
    finish_test("trigger during readout");

    apb_write(apb_pkg::CTRL, 32'h1);
    fire_trigger(spare);
    apb_read(apb_pkg::STATUS, rd, rd_err);
    expect_val("status.state", acq_pkg::IDLE, rd[1:0]);
    expect_val("status.fill_num", fill_cnt, rd[31:8]);
    apb_write(apb_pkg::CTRL, 32'h0);
    run_fill(10, go_cyc);
    wait_state(acq_pkg::SET_TRIG_ARM);
    check_sums(go_cyc, 10);
    check_pop();
    readout();
    finish_test("hold blocks trigger");

    for (int k = 0; k < `ACQ_FIFO_DEPTH; k++) begin
      run_fill(4 + k, go_cyc);
      wait_state(acq_pkg::SET_TRIG_ARM);
      readout();
    end
    run_fill(9, go_cyc);
    wait_state(acq_pkg::STORE_FILLNUM);
    apb_read(apb_pkg::STATUS, rd, rd_err);  // still stuck behind the full fifo
    expect_val("status.state", acq_pkg::STORE_FILLNUM, rd[1:0]);
    expect_val("status.count", `ACQ_FIFO_DEPTH, rd[6:4]);
    expect_val("arm", 0, arm);
    check_pop();
    wait_state(acq_pkg::SET_TRIG_ARM);
    check_sums(go_cyc, 9);
    readout();
    repeat (`ACQ_FIFO_DEPTH) check_pop();
    check_pop();
    expect_val("fifo_nonempty", 0, fifo_nonempty);
    finish_test("full fifo");

    apb_read(8'h40, rd, rd_err);
    expect_val("pslverr", 1, rd_err);
    expect_val("prdata", 0, rd);
    finish_test("unmapped offset");

    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             test_no, failed_tests, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
src/acq_pkg.sv
src/apb_pkg.sv
src/trigger_manager.sv
src/channel_accumulator.sv
src/fill_fifo.sv
src/acq_regs.sv
src/acq_top.sv
test/tb_acq_top.sv
